//--- store_queue.f
+incdir+logic
logic/sq_pkg.sv
logic/store_alloc.sv
logic/store_entries.sv
logic/store_commit.sv
logic/store_queue.sv
sim/store_queue_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the store queue testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module store_queue_tb \
  -f store_queue.f -o store_queue_sim &&
./obj_dir/store_queue_sim ||
{ echo "store queue simulation failed"; exit 1; }

//--- sim/store_queue_tb.sv
`include "sq_settings.svh"

module store_queue_tb
  import sq_pkg::*;
();

  localparam int CYCLE_LIMIT  = 4000;
  localparam int MAX_INFLIGHT = `SQ_DEPTH - 1;

  typedef struct packed {
    sq_idx_t  idx;
    logic     filled;
    sq_addr_t addr;
    sq_data_t data;
  } model_store_t;

  logic         clock;
  logic         reset;
  logic         dispatch_en;
  logic         rollback_en;
  sq_idx_t      rollback_idx;
  store_exec_t  exec;
  load_probe_t  probe;
  logic         retire_en;
  logic         cache_ack;
  logic         dispatch_ready;
  sq_idx_t      sq_idx;
  fwd_result_t  fwd;
  cache_write_t cache_wr;
  logic         retire_done;

  // Uncommitted stores, oldest first
  model_store_t stores [$];
  sq_idx_t      model_head;
  int           cycles;

  store_queue dut (.*);

  initial clock = 1'b0;
  always #2 clock = ~clock;

  function automatic sq_idx_t model_tail();
    return model_head + sq_idx_t'(stores.size());
  endfunction

  function automatic logic model_ready();
    return stores.size() < MAX_INFLIGHT;
  endfunction

  // Oldest to youngest below the bound, so the last match is the youngest
  function automatic fwd_result_t predict_fwd(load_probe_t p);
    fwd_result_t res;
    sq_idx_t     span;
    res  = '0;
    span = p.bound - model_head;
    if (p.valid) begin
      foreach (stores[i]) begin
        if (i < int'(span) && stores[i].filled && stores[i].addr == p.addr) begin
          res.hit  = 1'b1;
          res.data = stores[i].data;
        end
      end
    end
    return res;
  endfunction

  function automatic cache_write_t predict_cache(logic ret);
    cache_write_t res;
    res = '0;
    if (ret) begin
      res.wr_en = 1'b1;
      if (stores.size() > 0) begin
        res.addr = stores[0].addr;
        res.data = stores[0].data;
      end
    end
    return res;
  endfunction

  function automatic logic predict_done(logic ret, logic ack);
    return ret && ack && stores.size() > 0;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      report_failure("Run went past its cycle limit without finishing");
    end
  end

  always @(posedge clock) begin : model_update
    model_store_t s;
    sq_idx_t      span;
    if (reset) begin
      stores.delete();
      model_head = '0;
    end else begin
      if (exec.valid) begin
        foreach (stores[i]) begin
          if (stores[i].idx == exec.idx) begin
            s        = stores[i];
            s.filled = 1'b1;
            s.addr   = exec.addr;
            s.data   = exec.data;
            stores[i] = s;
          end
        end
      end
      if (rollback_en) begin
        span = rollback_idx - model_head;
        while (stores.size() > int'(span)) begin
          void'(stores.pop_back());
        end
      end else if (dispatch_en && model_ready()) begin
        s     = '0;
        s.idx = model_tail();
        stores.push_back(s);
      end
      if (retire_en && cache_ack && stores.size() > 0) begin
        void'(stores.pop_front());
        model_head = model_head + sq_idx_t'(1);
      end
    end
  end

  // Sampled mid-cycle, where inputs and outputs are settled
  ready_check: assert property (@(negedge clock) disable iff (reset)
    dispatch_ready == model_ready())
    else report_failure($sformatf("Mismatch dispatch_ready: got %h, expected %h",
                                  dispatch_ready, model_ready()));

  idx_check: assert property (@(negedge clock) disable iff (reset)
    sq_idx == model_tail())
    else report_failure($sformatf("Mismatch sq_idx: got %h, expected %h",
                                  sq_idx, model_tail()));

  fwd_check: assert property (@(negedge clock) disable iff (reset)
    fwd == predict_fwd(probe))
    else report_failure($sformatf("Mismatch fwd: got %h, expected %h",
                                  fwd, predict_fwd(probe)));

  cache_check: assert property (@(negedge clock) disable iff (reset)
    cache_wr == predict_cache(retire_en))
    else report_failure($sformatf("Mismatch cache_wr: got %h, expected %h",
                                  cache_wr, predict_cache(retire_en)));

  done_check: assert property (@(negedge clock) disable iff (reset)
    retire_done == predict_done(retire_en, cache_ack))
    else report_failure($sformatf("Mismatch retire_done: got %h, expected %h",
                                  retire_done, predict_done(retire_en, cache_ack)));

  stall_check: assert property (@(negedge clock) disable iff (reset)
    (retire_en && $past(retire_en) && !$past(cache_ack)) |-> cache_wr == $past(cache_wr))
    else report_failure("Cache write request changed while the commit was stalled");

  // Few addresses, so stores often collide
  function automatic sq_addr_t pool_addr();
    return sq_addr_t'(29'h100 + $urandom % 4);
  endfunction

  function automatic sq_data_t random_data();
    return {$urandom, $urandom};
  endfunction

  task automatic dispatch_store();
    @(posedge clock);
    dispatch_en <= 1'b1;
    @(posedge clock);
    dispatch_en <= 1'b0;
    @(negedge clock);
  endtask

  task automatic execute_store(input sq_idx_t idx, input sq_addr_t addr, input sq_data_t data);
    store_exec_t e;
    e.valid = 1'b1;
    e.idx   = idx;
    e.addr  = addr;
    e.data  = data;
    @(posedge clock);
    exec <= e;
    @(posedge clock);
    exec <= '0;
    @(negedge clock);
  endtask

  task automatic probe_load(input sq_addr_t addr, input sq_idx_t bound);
    load_probe_t p;
    p.valid = 1'b1;
    p.addr  = addr;
    p.bound = bound;
    @(posedge clock);
    probe <= p;
    @(posedge clock);
    probe <= '0;
    @(negedge clock);
  endtask

  task automatic probe_random();
    sq_idx_t bound;
    bound = model_head + sq_idx_t'($urandom % (stores.size() + 1));
    probe_load(pool_addr(), bound);
  endtask

  task automatic rollback_to(input sq_idx_t k);
    @(posedge clock);
    rollback_en  <= 1'b1;
    rollback_idx <= k;
    @(posedge clock);
    rollback_en <= 1'b0;
    @(negedge clock);
  endtask

  // Retire stays high, the cache acknowledges about one cycle in three
  task automatic commit_stores(input int count);
    int   done;
    logic ack;
    done = 0;
    while (done < count) begin
      ack = ($urandom % 3) == 0;
      @(posedge clock);
      retire_en <= 1'b1;
      cache_ack <= ack;
      if (ack) begin
        done++;
      end
    end
    @(posedge clock);
    retire_en <= 1'b0;
    cache_ack <= 1'b0;
    @(negedge clock);
  endtask

  task automatic execute_pending();
    sq_idx_t order [$];
    sq_idx_t swap;
    int      pick;
    foreach (stores[i]) begin
      if (!stores[i].filled) begin
        order.push_back(stores[i].idx);
      end
    end
    for (int i = order.size() - 1; i > 0; i--) begin
      pick        = int'($urandom % (i + 1));
      swap        = order[i];
      order[i]    = order[pick];
      order[pick] = swap;
    end
    foreach (order[i]) begin
      execute_store(order[i], pool_addr(), random_data());
      probe_random();
    end
  endtask

  initial begin : stimulus
    int       free;
    int       n;
    sq_idx_t  k;
    sq_addr_t lone;
    void'($urandom(95));
    reset        <= 1'b1;
    dispatch_en  <= 1'b0;
    rollback_en  <= 1'b0;
    rollback_idx <= '0;
    exec         <= '0;
    probe        <= '0;
    retire_en    <= 1'b0;
    cache_ack    <= 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);

    // Fill to full, then one dispatch that must be refused
    repeat (MAX_INFLIGHT + 1) dispatch_store();

    for (int r = 0; r < 10; r++) begin
      free = MAX_INFLIGHT - stores.size();
      if (free > 0) begin
        n = 1 + int'($urandom % free);
        repeat (n) dispatch_store();
      end
      execute_pending();
      repeat (3) probe_random();
      commit_stores(1 + int'($urandom % stores.size()));
    end

    // Squash from a random store and reuse its slot
    for (int r = 0; r < 5; r++) begin
      free = MAX_INFLIGHT - stores.size();
      repeat (free) dispatch_store();
      execute_pending();
      k    = model_head + sq_idx_t'($urandom % stores.size());
      lone = sq_addr_t'(29'h1f00_0000 + r);
      execute_store(k, lone, random_data());
      probe_load(lone, model_tail());
      rollback_to(k);
      dispatch_store();
      probe_load(lone, model_tail());
      execute_pending();
      commit_stores(stores.size());
    end

    $display("No errors");
    $finish;
  end

endmodule

//--- logic/store_queue.sv
`include "sq_settings.svh"

module store_queue
  import sq_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         dispatch_en,
  input  logic         rollback_en,
  input  sq_idx_t      rollback_idx,
  input  store_exec_t  exec,
  input  load_probe_t  probe,
  input  logic         retire_en,
  input  logic         cache_ack,
  output logic         dispatch_ready,
  output sq_idx_t      sq_idx,
  output fwd_result_t  fwd,
  output cache_write_t cache_wr,
  output logic         retire_done
);

  sq_idx_t   head;
  sq_idx_t   tail;
  logic      alloc_fire;
  sq_entry_t head_entry;

  // New store lands at the current tail
  assign sq_idx = tail;

  store_alloc u_alloc (
    .clock          (clock),
    .reset          (reset),
    .dispatch_en    (dispatch_en),
    .rollback_en    (rollback_en),
    .rollback_idx   (rollback_idx),
    .head           (head),
    .tail           (tail),
    .alloc_fire     (alloc_fire),
    .dispatch_ready (dispatch_ready)
  );

  store_entries u_entries (
    .clock      (clock),
    .reset      (reset),
    .tail       (tail),
    .alloc_fire (alloc_fire),
    .head       (head),
    .exec       (exec),
    .probe      (probe),
    .head_entry (head_entry),
    .fwd        (fwd)
  );

  store_commit u_commit (
    .clock       (clock),
    .reset       (reset),
    .retire_en   (retire_en),
    .cache_ack   (cache_ack),
    .head_entry  (head_entry),
    .tail        (tail),
    .head        (head),
    .cache_wr    (cache_wr),
    .retire_done (retire_done)
  );

endmodule

//--- logic/store_commit.sv
`include "sq_settings.svh"

module store_commit
  import sq_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         retire_en,
  input  logic         cache_ack,
  input  sq_entry_t    head_entry,
  input  sq_idx_t      tail,
  output sq_idx_t      head,
  output cache_write_t cache_wr,
  output logic         retire_done
);

  logic commit_fire;

  // The head store leaves only once the cache has taken it
  assign commit_fire = retire_en && cache_ack;
  assign retire_done = commit_fire;

  always_comb begin
    cache_wr = '0;
    if (retire_en) begin
      cache_wr.wr_en = 1'b1;
      cache_wr.addr  = head_entry.addr;
      cache_wr.data  = head_entry.data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
    end else if (commit_fire) begin
      head <= head + sq_idx_t'(1);
    end
  end

  retire_not_empty: assert property (
    @(posedge clock) disable iff (reset)
    retire_en |-> head != tail
  ) else $error("retire with an empty store queue, head %0d", head);

  retire_filled: assert property (
    @(posedge clock) disable iff (reset)
    retire_en |-> head_entry.filled
  ) else $error("retire of store %0d before its execute", head);

endmodule

//--- logic/store_entries.sv
`include "sq_settings.svh"

module store_entries
  import sq_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  sq_idx_t     tail,
  input  logic        alloc_fire,
  input  sq_idx_t     head,
  input  store_exec_t exec,
  input  load_probe_t probe,
  output sq_entry_t   head_entry,
  output fwd_result_t fwd
);

  sq_entry_t entries [`SQ_DEPTH];

  sq_idx_t used_span;
  sq_idx_t exec_span;
  sq_idx_t bound_span;

  // Only the filled flags are cleared by reset
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `SQ_DEPTH; i++) begin
        entries[i].filled <= 1'b0;
      end
    end else begin
      if (alloc_fire) begin
        entries[tail].filled <= 1'b0;
      end
      if (exec.valid) begin
        entries[exec.idx].filled <= 1'b1;
        entries[exec.idx].addr   <= exec.addr;
        entries[exec.idx].data   <= exec.data;
      end
    end
  end

  assign head_entry = entries[head];

  // Walk youngest first from bound minus one back to the head
  always_comb begin
    sq_idx_t span;
    sq_idx_t idx;
    span = probe.bound - head;
    fwd  = '0;
    for (int i = 0; i < `SQ_DEPTH; i++) begin
      idx = probe.bound - sq_idx_t'(i + 1);
      if (probe.valid && !fwd.hit && i < int'(span)) begin
        if (entries[idx].filled && entries[idx].addr == probe.addr) begin
          fwd.hit  = 1'b1;
          fwd.data = entries[idx].data;
        end
      end
    end
  end

  assign used_span  = tail - head;
  assign exec_span  = exec.idx - head;
  assign bound_span = probe.bound - head;

  // Execute must target a dispatched, uncommitted store
  exec_in_range: assert property (
    @(posedge clock) disable iff (reset)
    exec.valid |-> exec_span < used_span
  ) else $error("execute index %0d outside head %0d to tail %0d", exec.idx, head, tail);

  // A load bound cannot point past the current tail
  bound_in_range: assert property (
    @(posedge clock) disable iff (reset)
    probe.valid |-> bound_span <= used_span
  ) else $error("probe bound %0d outside head %0d to tail %0d", probe.bound, head, tail);

endmodule

//--- logic/store_alloc.sv
`include "sq_settings.svh"

module store_alloc
  import sq_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    dispatch_en,
  input  logic    rollback_en,
  input  sq_idx_t rollback_idx,
  input  sq_idx_t head,
  output sq_idx_t tail,
  output logic    alloc_fire,
  output logic    dispatch_ready
);

  sq_idx_t tail_plus_one;
  sq_idx_t used_span;
  sq_idx_t rollback_span;

  assign tail_plus_one = tail + sq_idx_t'(1);

  // Full when one more store would land on the head
  assign dispatch_ready = tail_plus_one != head;

  // Rollback takes the cycle and drops a dispatch beside it
  assign alloc_fire = dispatch_en && dispatch_ready && !rollback_en;

  always_ff @(posedge clock) begin
    if (reset) begin
      tail <= '0;
    end else if (rollback_en) begin
      tail <= rollback_idx;
    end else if (alloc_fire) begin
      tail <= tail_plus_one;
    end
  end

  // Distances from head modulo depth
  assign used_span     = tail - head;
  assign rollback_span = rollback_idx - head;

  // Tail may only move back inside the stores still held
  rollback_in_range: assert property (
    @(posedge clock) disable iff (reset)
    rollback_en |-> rollback_span <= used_span
  ) else $error("rollback index %0d outside head %0d to tail %0d", rollback_idx, head, tail);

endmodule

//--- logic/sq_pkg.sv
`include "sq_settings.svh"

package sq_pkg;

  localparam int SQ_IDX_W = $clog2(`SQ_DEPTH);

  typedef logic [SQ_IDX_W-1:0]   sq_idx_t;
  typedef logic [`SQ_ADDR_W-1:0] sq_addr_t;
  typedef logic [`SQ_DATA_W-1:0] sq_data_t;

  typedef struct packed {
    logic     filled;
    sq_addr_t addr;
    sq_data_t data;
  } sq_entry_t;

  typedef struct packed {
    logic     valid;
    sq_idx_t  idx;
    sq_addr_t addr;
    sq_data_t data;
  } store_exec_t;

  // Bound is the tail seen by the load at dispatch
  typedef struct packed {
    logic     valid;
    sq_addr_t addr;
    sq_idx_t  bound;
  } load_probe_t;

  typedef struct packed {
    logic     hit;
    sq_data_t data;
  } fwd_result_t;

  typedef struct packed {
    logic     wr_en;
    sq_addr_t addr;
    sq_data_t data;
  } cache_write_t;

endpackage

//--- logic/sq_settings.svh
`ifndef SQ_SETTINGS_SVH
`define SQ_SETTINGS_SVH

// Store entries as a power of two with one slot always empty
`define SQ_DEPTH 8

// Doubleword address without the byte offset
`define SQ_ADDR_W 29

`define SQ_DATA_W 64

`endif
